// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= exu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+logic
logic/exu_pkg.sv
logic/alu.sv
logic/issue_unit.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/exu_core.sv
test/tb_clock_gen.sv
test/exu_tb.sv

// File: logic/alu.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module alu (
  input  exu_pkg::alu_op_t alu_op,
  input  exu_pkg::word_t   operand1,
  input  exu_pkg::word_t   operand2,
  output exu_pkg::word_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  logic       equal;

  assign shamt       = operand2[4:0];
  assign lt_signed   = $signed(operand1) < $signed(operand2);
  assign lt_unsigned = operand1 < operand2;
  assign equal       = operand1 == operand2;

  always_comb begin
    result = '0;
    case (alu_op)
      `EXU_OP_ADD:  result = operand1 + operand2;
      `EXU_OP_SUB:  result = operand1 - operand2;
      `EXU_OP_AND:  result = operand1 & operand2;
      `EXU_OP_OR:   result = operand1 | operand2;
      `EXU_OP_XOR:  result = operand1 ^ operand2;
      `EXU_OP_SLL:  result = operand1 << shamt;
      `EXU_OP_SRL:  result = operand1 >> shamt;
      `EXU_OP_SRA:  result = $signed(operand1) >>> shamt;
      // Set and branch compares only drive bit 0
      `EXU_OP_SLT:  result[0] = lt_signed;
      `EXU_OP_SLTU: result[0] = lt_unsigned;
      `EXU_OP_EQ:   result[0] = equal;
      `EXU_OP_NE:   result[0] = !equal;
      `EXU_OP_LT:   result[0] = lt_signed;
      `EXU_OP_GE:   result[0] = !lt_signed;
      `EXU_OP_LTU:  result[0] = lt_unsigned;
      `EXU_OP_GEU:  result[0] = !lt_unsigned;
      default:      result = '0;
    endcase
  end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module execute_stage (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               flush,
  input  logic               issue_valid,
  input  exu_pkg::word_t     issue_pc,
  input  exu_pkg::alu_op_t   issue_alu,
  input  exu_pkg::reg_idx_t  issue_rd,
  input  exu_pkg::npc_sel_t  issue_npc_sel,
  input  exu_pkg::wb_sel_t   issue_wb_sel,
  input  exu_pkg::word_t     issue_imm,
  input  exu_pkg::word_t     issue_operand1,
  input  exu_pkg::word_t     issue_operand2,
  output logic               ex_valid,
  output exu_pkg::reg_idx_t  ex_rd,
  output exu_pkg::word_t     ex_pc,
  output exu_pkg::word_t     ex_wdata,
  output exu_pkg::word_t     ex_npc
);

  logic              valid_q;
  exu_pkg::alu_op_t  alu_op_q;
  exu_pkg::word_t    operand1_q;
  exu_pkg::word_t    operand2_q;
  exu_pkg::reg_idx_t rd_q;
  exu_pkg::npc_sel_t npc_sel_q;
  exu_pkg::wb_sel_t  wb_sel_q;
  exu_pkg::word_t    pc_q;
  exu_pkg::word_t    snpc_q;
  exu_pkg::word_t    dnpc_q;
  exu_pkg::word_t    alu_result;

  // An op strobed together with flush never enters the stage
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid && !flush;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_valid) begin
      alu_op_q   <= issue_alu;
      operand1_q <= issue_operand1;
      operand2_q <= issue_operand2;
      rd_q       <= issue_rd;
      npc_sel_q  <= issue_npc_sel;
      wb_sel_q   <= issue_wb_sel;
      pc_q       <= issue_pc;
      snpc_q     <= issue_pc + `EXU_PC_STEP;
      dnpc_q     <= issue_pc + issue_imm;
    end
  end

  alu u_alu (
    .alu_op   (alu_op_q),
    .operand1 (operand1_q),
    .operand2 (operand2_q),
    .result   (alu_result)
  );

  always_comb begin
    case (npc_sel_q)
      `EXU_NPC_JAL:    ex_npc = dnpc_q;
      `EXU_NPC_JALR:   ex_npc = {alu_result[`EXU_XLEN-1:1], 1'b0};
      `EXU_NPC_BRANCH: ex_npc = alu_result[0] ? dnpc_q : snpc_q;
      default:         ex_npc = snpc_q;
    endcase
  end

  // For auipc the ALU already adds pc and imm
  always_comb begin
    case (wb_sel_q)
      `EXU_WB_LINK: ex_wdata = snpc_q;
      default:      ex_wdata = alu_result;
    endcase
  end

  assign ex_valid = valid_q;
  assign ex_rd    = rd_q;
  assign ex_pc    = pc_q;

  // A known result also means the forwarded operands were known
  a_wdata_known : assert property (
    @(posedge clock) disable iff (!arst_n)
    ex_valid |-> !$isunknown(ex_wdata)
  ) else $error("execute result is unknown while valid");

endmodule

// File: logic/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

`define EXU_XLEN    32
`define EXU_REG_W   5
`define EXU_OP_W    4
`define EXU_SEL_W   2
`define EXU_PC_STEP 32'd4

// ALU operation codes
// Compares return their flag in bit 0
`define EXU_OP_ADD  4'd0
`define EXU_OP_SUB  4'd1
`define EXU_OP_AND  4'd2
`define EXU_OP_OR   4'd3
`define EXU_OP_XOR  4'd4
`define EXU_OP_SLL  4'd5
`define EXU_OP_SRL  4'd6
`define EXU_OP_SRA  4'd7
`define EXU_OP_SLT  4'd8
`define EXU_OP_SLTU 4'd9
`define EXU_OP_EQ   4'd10
`define EXU_OP_NE   4'd11
`define EXU_OP_LT   4'd12
`define EXU_OP_GE   4'd13
`define EXU_OP_LTU  4'd14
`define EXU_OP_GEU  4'd15

// Next-PC select
`define EXU_NPC_SEQ    2'd0
`define EXU_NPC_JAL    2'd1
`define EXU_NPC_JALR   2'd2
`define EXU_NPC_BRANCH 2'd3

// Write-back value select
`define EXU_WB_ALU   2'd0
`define EXU_WB_LINK  2'd1
`define EXU_WB_AUIPC 2'd2

`endif

// File: logic/exu_core.sv
`timescale 1ns/1ps

module exu_core (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               flush,
  input  logic               op_valid,
  input  exu_pkg::word_t     op_pc,
  input  exu_pkg::alu_op_t   op_alu,
  input  exu_pkg::reg_idx_t  op_rd,
  input  exu_pkg::reg_idx_t  op_rs1,
  input  exu_pkg::reg_idx_t  op_rs2,
  input  exu_pkg::word_t     op_imm,
  input  logic               op_use_imm,
  input  exu_pkg::npc_sel_t  op_npc_sel,
  input  exu_pkg::wb_sel_t   op_wb_sel,
  output logic               result_valid,
  output exu_pkg::reg_idx_t  result_rd,
  output exu_pkg::word_t     result_data,
  output exu_pkg::word_t     result_pc,
  output logic               redirect,
  output exu_pkg::word_t     redirect_pc
);

  logic              issue_valid;
  exu_pkg::word_t    issue_pc;
  exu_pkg::alu_op_t  issue_alu;
  exu_pkg::reg_idx_t issue_rd;
  exu_pkg::npc_sel_t issue_npc_sel;
  exu_pkg::wb_sel_t  issue_wb_sel;
  exu_pkg::word_t    issue_imm;
  exu_pkg::word_t    issue_operand1;
  exu_pkg::word_t    issue_operand2;
  logic              ex_valid;
  exu_pkg::reg_idx_t ex_rd;
  exu_pkg::word_t    ex_pc;
  exu_pkg::word_t    ex_wdata;
  exu_pkg::word_t    ex_npc;

  // The retiring op is also the register-file write port
  issue_unit u_issue (
    .clock          (clock),
    .arst_n         (arst_n),
    .op_valid       (op_valid),
    .op_pc          (op_pc),
    .op_alu         (op_alu),
    .op_rd          (op_rd),
    .op_rs1         (op_rs1),
    .op_rs2         (op_rs2),
    .op_imm         (op_imm),
    .op_use_imm     (op_use_imm),
    .op_npc_sel     (op_npc_sel),
    .op_wb_sel      (op_wb_sel),
    .ex_valid       (ex_valid),
    .ex_rd          (ex_rd),
    .ex_wdata       (ex_wdata),
    .wb_valid       (result_valid),
    .wb_rd          (result_rd),
    .wb_data        (result_data),
    .issue_valid    (issue_valid),
    .issue_pc       (issue_pc),
    .issue_alu      (issue_alu),
    .issue_rd       (issue_rd),
    .issue_npc_sel  (issue_npc_sel),
    .issue_wb_sel   (issue_wb_sel),
    .issue_imm      (issue_imm),
    .issue_operand1 (issue_operand1),
    .issue_operand2 (issue_operand2)
  );

  execute_stage u_execute (
    .clock          (clock),
    .arst_n         (arst_n),
    .flush          (flush),
    .issue_valid    (issue_valid),
    .issue_pc       (issue_pc),
    .issue_alu      (issue_alu),
    .issue_rd       (issue_rd),
    .issue_npc_sel  (issue_npc_sel),
    .issue_wb_sel   (issue_wb_sel),
    .issue_imm      (issue_imm),
    .issue_operand1 (issue_operand1),
    .issue_operand2 (issue_operand2),
    .ex_valid       (ex_valid),
    .ex_rd          (ex_rd),
    .ex_pc          (ex_pc),
    .ex_wdata       (ex_wdata),
    .ex_npc         (ex_npc)
  );

  writeback_stage u_writeback (
    .clock       (clock),
    .arst_n      (arst_n),
    .flush       (flush),
    .ex_valid    (ex_valid),
    .ex_rd       (ex_rd),
    .ex_pc       (ex_pc),
    .ex_wdata    (ex_wdata),
    .ex_npc      (ex_npc),
    .wb_valid    (result_valid),
    .wb_rd       (result_rd),
    .wb_data     (result_data),
    .result_pc   (result_pc),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

endmodule

// File: logic/exu_pkg.sv
`include "exu_consts.svh"

package exu_pkg;

  // One data word or program counter
  typedef logic [`EXU_XLEN-1:0] word_t;

  // Architectural register index
  typedef logic [`EXU_REG_W-1:0] reg_idx_t;

  // ALU operation code
  typedef logic [`EXU_OP_W-1:0] alu_op_t;

  // Next-PC source of an op
  typedef logic [`EXU_SEL_W-1:0] npc_sel_t;

  // Source of the value written to rd
  typedef logic [`EXU_SEL_W-1:0] wb_sel_t;

endpackage

// File: logic/issue_unit.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module issue_unit (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               op_valid,
  input  exu_pkg::word_t     op_pc,
  input  exu_pkg::alu_op_t   op_alu,
  input  exu_pkg::reg_idx_t  op_rd,
  input  exu_pkg::reg_idx_t  op_rs1,
  input  exu_pkg::reg_idx_t  op_rs2,
  input  exu_pkg::word_t     op_imm,
  input  logic               op_use_imm,
  input  exu_pkg::npc_sel_t  op_npc_sel,
  input  exu_pkg::wb_sel_t   op_wb_sel,
  input  logic               ex_valid,
  input  exu_pkg::reg_idx_t  ex_rd,
  input  exu_pkg::word_t     ex_wdata,
  input  logic               wb_valid,
  input  exu_pkg::reg_idx_t  wb_rd,
  input  exu_pkg::word_t     wb_data,
  output logic               issue_valid,
  output exu_pkg::word_t     issue_pc,
  output exu_pkg::alu_op_t   issue_alu,
  output exu_pkg::reg_idx_t  issue_rd,
  output exu_pkg::npc_sel_t  issue_npc_sel,
  output exu_pkg::wb_sel_t   issue_wb_sel,
  output exu_pkg::word_t     issue_imm,
  output exu_pkg::word_t     issue_operand1,
  output exu_pkg::word_t     issue_operand2
);

  exu_pkg::word_t regs [2**`EXU_REG_W];
  exu_pkg::word_t rs1_value;
  exu_pkg::word_t rs2_value;

  // The youngest producer wins and x0 always reads zero
  function automatic exu_pkg::word_t read_operand(input exu_pkg::reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (ex_valid && ex_rd == idx) begin
      return ex_wdata;
    end else if (wb_valid && wb_rd == idx) begin
      return wb_data;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**`EXU_REG_W; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  always_comb begin
    rs1_value = read_operand(op_rs1);
    rs2_value = read_operand(op_rs2);
  end

  assign issue_valid    = op_valid;
  assign issue_pc       = op_pc;
  assign issue_alu      = op_alu;
  assign issue_rd       = op_rd;
  assign issue_npc_sel  = op_npc_sel;
  assign issue_wb_sel   = op_wb_sel;
  assign issue_imm      = op_imm;
  assign issue_operand1 = (op_wb_sel == `EXU_WB_AUIPC) ? op_pc : rs1_value;
  assign issue_operand2 = op_use_imm ? op_imm : rs2_value;

endmodule

// File: logic/writeback_stage.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module writeback_stage (
  input  logic               clock,
  input  logic               arst_n,
  input  logic               flush,
  input  logic               ex_valid,
  input  exu_pkg::reg_idx_t  ex_rd,
  input  exu_pkg::word_t     ex_pc,
  input  exu_pkg::word_t     ex_wdata,
  input  exu_pkg::word_t     ex_npc,
  output logic               wb_valid,
  output exu_pkg::reg_idx_t  wb_rd,
  output exu_pkg::word_t     wb_data,
  output exu_pkg::word_t     result_pc,
  output logic               redirect,
  output exu_pkg::word_t     redirect_pc
);

  logic              valid_q;
  logic              redirect_q;
  exu_pkg::reg_idx_t rd_q;
  exu_pkg::word_t    data_q;
  exu_pkg::word_t    pc_q;
  exu_pkg::word_t    npc_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q    <= 1'b0;
      redirect_q <= 1'b0;
    end else begin
      valid_q    <= ex_valid && !flush;
      // Anything but a fall-through needs fetch to restart
      redirect_q <= ex_valid && !flush && (ex_npc != ex_pc + `EXU_PC_STEP);
    end
  end

  always_ff @(posedge clock) begin
    if (ex_valid) begin
      rd_q   <= ex_rd;
      data_q <= ex_wdata;
      pc_q   <= ex_pc;
      npc_q  <= ex_npc;
    end
  end

  assign wb_valid    = valid_q;
  assign wb_rd       = rd_q;
  assign wb_data     = data_q;
  assign result_pc   = pc_q;
  assign redirect    = redirect_q;
  assign redirect_pc = npc_q;

  // An unknown rd or next pc would corrupt the register file or the redirect
  a_retire_known : assert property (
    @(posedge clock) disable iff (!arst_n)
    ex_valid |-> !$isunknown({ex_rd, ex_pc, ex_npc})
  ) else $error("retiring op has unknown rd, pc or next pc");

endmodule

// File: test/exu_tb.sv
`timescale 1ns/1ps
`include "exu_consts.svh"

module exu_tb;

  logic              clock;
  logic              arst_n;
  logic              flush;
  logic              op_valid;
  exu_pkg::word_t    op_pc;
  exu_pkg::alu_op_t  op_alu;
  exu_pkg::reg_idx_t op_rd;
  exu_pkg::reg_idx_t op_rs1;
  exu_pkg::reg_idx_t op_rs2;
  exu_pkg::word_t    op_imm;
  logic              op_use_imm;
  exu_pkg::npc_sel_t op_npc_sel;
  exu_pkg::wb_sel_t  op_wb_sel;
  logic              result_valid;
  exu_pkg::reg_idx_t result_rd;
  exu_pkg::word_t    result_data;
  exu_pkg::word_t    result_pc;
  logic              redirect;
  exu_pkg::word_t    redirect_pc;

  // Architectural state as the model sees it, and the expected retire stream
  exu_pkg::word_t    shadow_regs [32];
  exu_pkg::reg_idx_t exp_rd_q [$];
  exu_pkg::word_t    exp_data_q [$];
  exu_pkg::word_t    exp_pc_q [$];
  logic              exp_redirect_q [$];
  exu_pkg::word_t    exp_npc_q [$];
  int                exp_cycle_q [$];

  int             cycle = 0;
  int             checks = 0;
  int             errors = 0;
  logic           timed_out;
  integer         seed;
  exu_pkg::word_t next_pc;

  tb_clock_gen #(.PERIOD_NS(40)) u_clock (.clock(clock));

  exu_core u_dut (
    .clock        (clock),
    .arst_n       (arst_n),
    .flush        (flush),
    .op_valid     (op_valid),
    .op_pc        (op_pc),
    .op_alu       (op_alu),
    .op_rd        (op_rd),
    .op_rs1       (op_rs1),
    .op_rs2       (op_rs2),
    .op_imm       (op_imm),
    .op_use_imm   (op_use_imm),
    .op_npc_sel   (op_npc_sel),
    .op_wb_sel    (op_wb_sel),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result_data  (result_data),
    .result_pc    (result_pc),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc)
  );

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  // Executes one op in program order and queues what must retire two cycles later
  function automatic void exu_model(input exu_pkg::word_t pc, input exu_pkg::alu_op_t alu_op,
      input exu_pkg::reg_idx_t rd, input exu_pkg::reg_idx_t rs1, input exu_pkg::reg_idx_t rs2,
      input exu_pkg::word_t imm, input logic use_imm, input exu_pkg::npc_sel_t npc_sel,
      input exu_pkg::wb_sel_t wb_sel, input int strobe_cycle);
    exu_pkg::word_t a;
    exu_pkg::word_t b;
    exu_pkg::word_t res;
    exu_pkg::word_t npc;
    exu_pkg::word_t data;
    logic           lt_s;
    logic           lt_u;
    a    = (wb_sel == `EXU_WB_AUIPC) ? pc : shadow_regs[rs1];
    b    = use_imm ? imm : shadow_regs[rs2];
    lt_u = a < b;
    // Flipping the sign bits turns a signed compare into an unsigned one
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (alu_op)
      `EXU_OP_ADD:  res = a + b;
      `EXU_OP_SUB:  res = a + ~b + 32'd1;
      `EXU_OP_AND:  res = a & b;
      `EXU_OP_OR:   res = a | b;
      `EXU_OP_XOR:  res = a ^ b;
      `EXU_OP_SLL:  res = a << b[4:0];
      `EXU_OP_SRL:  res = a >> b[4:0];
      `EXU_OP_SRA:  res = (a >> b[4:0]) | ~({32{1'b1}} >> b[4:0]) & {32{a[31]}};
      `EXU_OP_SLT:  res = {31'd0, lt_s};
      `EXU_OP_SLTU: res = {31'd0, lt_u};
      `EXU_OP_EQ:   res = {31'd0, a == b};
      `EXU_OP_NE:   res = {31'd0, a != b};
      `EXU_OP_LT:   res = {31'd0, lt_s};
      `EXU_OP_GE:   res = {31'd0, !lt_s};
      `EXU_OP_LTU:  res = {31'd0, lt_u};
      default:      res = {31'd0, !lt_u};
    endcase
    case (npc_sel)
      `EXU_NPC_JAL:    npc = pc + imm;
      `EXU_NPC_JALR:   npc = {res[31:1], 1'b0};
      `EXU_NPC_BRANCH: npc = res[0] ? pc + imm : pc + 32'd4;
      default:         npc = pc + 32'd4;
    endcase
    case (wb_sel)
      `EXU_WB_LINK:  data = pc + 32'd4;
      `EXU_WB_AUIPC: data = pc + imm;
      default:       data = res;
    endcase
    if (rd != 5'd0) begin
      shadow_regs[rd] = data;
    end
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
    exp_pc_q.push_back(pc);
    exp_redirect_q.push_back(npc != pc + 32'd4);
    exp_npc_q.push_back(npc);
    exp_cycle_q.push_back(strobe_cycle);
  endfunction

  // A dropped op (keep low) is driven but never reaches the model
  task automatic send_op(input logic keep, input logic fl, input exu_pkg::alu_op_t alu,
      input exu_pkg::reg_idx_t rd, input exu_pkg::reg_idx_t rs1, input exu_pkg::reg_idx_t rs2,
      input exu_pkg::word_t imm, input logic use_imm, input exu_pkg::npc_sel_t npc_sel,
      input exu_pkg::wb_sel_t wb_sel);
    @(negedge clock);
    op_valid   = 1'b1;
    flush      = fl;
    op_pc      = next_pc;
    op_alu     = alu;
    op_rd      = rd;
    op_rs1     = rs1;
    op_rs2     = rs2;
    op_imm     = imm;
    op_use_imm = use_imm;
    op_npc_sel = npc_sel;
    op_wb_sel  = wb_sel;
    if (keep) begin
      exu_model(next_pc, alu, rd, rs1, rs2, imm, use_imm, npc_sel, wb_sel, cycle);
    end
    next_pc = next_pc + 32'd4;
  endtask

  task automatic alu_imm(input exu_pkg::reg_idx_t rd, input exu_pkg::reg_idx_t rs1,
      input exu_pkg::alu_op_t alu, input exu_pkg::word_t imm);
    send_op(1'b1, 1'b0, alu, rd, rs1, 5'd0, imm, 1'b1, `EXU_NPC_SEQ, `EXU_WB_ALU);
  endtask

  task automatic alu_reg(input exu_pkg::reg_idx_t rd, input exu_pkg::reg_idx_t rs1,
      input exu_pkg::reg_idx_t rs2, input exu_pkg::alu_op_t alu);
    send_op(1'b1, 1'b0, alu, rd, rs1, rs2, 32'd0, 1'b0, `EXU_NPC_SEQ, `EXU_WB_ALU);
  endtask

  task automatic idle_cycle();
    @(negedge clock);
    op_valid = 1'b0;
    flush    = 1'b0;
  endtask

  // Waits until every queued op has retired, then reports the test
  task automatic drain(input string name, input int base_errors);
    int waited;
    waited = 0;
    idle_cycle();
    while (exp_rd_q.size() != 0 && waited < 20) begin
      idle_cycle();
      waited++;
    end
    if (exp_rd_q.size() != 0) begin
      $display("%s timed out with %0d results that never appeared", name, exp_rd_q.size());
      timed_out = 1'b1;
    end else begin
      $display("%s done, %0d errors", name, errors - base_errors);
    end
  endtask

  task automatic check_word(input string what, input exu_pkg::word_t got,
      input exu_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  always @(negedge clock) begin
    if (arst_n && result_valid) begin
      if (exp_rd_q.size() == 0) begin
        $display("Error at %0t: a result retired with no op outstanding", $time);
        errors++;
      end else begin
        check_word("result_rd", {27'd0, result_rd}, {27'd0, exp_rd_q.pop_front()});
        check_word("result_data", result_data, exp_data_q.pop_front());
        check_word("result_pc", result_pc, exp_pc_q.pop_front());
        check_word("redirect", {31'd0, redirect}, {31'd0, exp_redirect_q.pop_front()});
        check_word("redirect_pc", redirect_pc, exp_npc_q.pop_front());
        check_word("latency", cycle - exp_cycle_q.pop_front(), 32'd2);
      end
    end
  end

  initial begin
    int             i;
    int             base;
    exu_pkg::word_t w;
    exu_pkg::reg_idx_t rd;
    seed       = 85;
    timed_out  = 1'b0;
    next_pc    = 32'h0000_1000;
    arst_n     = 1'b0;
    flush      = 1'b0;
    op_valid   = 1'b0;
    op_pc      = '0;
    op_alu     = '0;
    op_rd      = '0;
    op_rs1     = '0;
    op_rs2     = '0;
    op_imm     = '0;
    op_use_imm = 1'b0;
    op_npc_sel = '0;
    op_wb_sel  = '0;
    for (i = 0; i < 32; i++) begin
      shadow_regs[i] = '0;
    end
    repeat (8) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;

    base = errors;
    for (i = 1; i < 32; i++) begin
      alu_imm(i[4:0], 5'd0, `EXU_OP_ADD, $random(seed));
    end
    for (i = 0; i < 64; i++) begin
      w  = $random(seed);
      rd = (w[4:0] == 5'd0) ? 5'd1 : w[4:0];
      send_op(1'b1, 1'b0, i[3:0], rd, w[9:5], w[14:10], $random(seed), w[15],
              `EXU_NPC_SEQ, `EXU_WB_ALU);
    end
    drain("test 1 random ALU ops", base);

    base = errors;
    for (i = 0; i < 8; i++) begin
      alu_reg(5'd5, 5'd5, 5'd6, `EXU_OP_ADD);
      alu_reg(5'd6, 5'd5, 5'd6, `EXU_OP_SUB);
    end
    for (i = 0; i < 6; i++) begin
      alu_imm(5'd7, 5'd7, `EXU_OP_XOR, $random(seed));
      idle_cycle();
      alu_reg(5'd8, 5'd7, 5'd5, `EXU_OP_SLL);
    end
    drain("test 2 dependent chains", base);

    base = errors;
    send_op(1'b1, 1'b0, `EXU_OP_ADD, 5'd1, 5'd0, 5'd0, 32'h100, 1'b1, `EXU_NPC_JAL,
            `EXU_WB_LINK);
    alu_imm(5'd2, 5'd0, `EXU_OP_ADD, 32'h2001);
    send_op(1'b1, 1'b0, `EXU_OP_ADD, 5'd1, 5'd2, 5'd0, 32'h10, 1'b1, `EXU_NPC_JALR,
            `EXU_WB_LINK);
    alu_imm(5'd3, 5'd0, `EXU_OP_ADD, 32'd5);
    alu_imm(5'd4, 5'd0, `EXU_OP_ADD, 32'd5);
    alu_imm(5'd9, 5'd0, `EXU_OP_ADD, 32'hFFFF_FFFD);
    for (i = 10; i < 16; i++) begin
      send_op(1'b1, 1'b0, i[3:0], 5'd0, 5'd3, 5'd4, 32'h40, 1'b0, `EXU_NPC_BRANCH,
              `EXU_WB_ALU);
      send_op(1'b1, 1'b0, i[3:0], 5'd0, 5'd3, 5'd9, 32'hFFFF_FFC0, 1'b0,
              `EXU_NPC_BRANCH, `EXU_WB_ALU);
      alu_reg(5'd1, 5'd1, 5'd3, `EXU_OP_ADD);
    end
    drain("test 3 jumps and branches", base);

    base = errors;
    send_op(1'b1, 1'b0, `EXU_OP_ADD, 5'd10, 5'd0, 5'd0, 32'h0001_2000, 1'b1, `EXU_NPC_SEQ,
            `EXU_WB_AUIPC);
    alu_imm(5'd0, 5'd1, `EXU_OP_ADD, 32'd77);
    alu_reg(5'd11, 5'd0, 5'd0, `EXU_OP_ADD);
    alu_reg(5'd12, 5'd0, 5'd10, `EXU_OP_OR);
    idle_cycle();
    alu_imm(5'd13, 5'd0, `EXU_OP_ADD, 32'd0);
    drain("test 4 auipc and x0", base);

    // The op ahead of the flush and the op strobed with it both vanish
    base = errors;
    alu_imm(5'd14, 5'd0, `EXU_OP_ADD, 32'h11);
    alu_imm(5'd15, 5'd14, `EXU_OP_ADD, 32'd1);
    send_op(1'b0, 1'b0, `EXU_OP_ADD, 5'd14, 5'd0, 5'd0, 32'hDEAD, 1'b1, `EXU_NPC_SEQ,
            `EXU_WB_ALU);
    send_op(1'b0, 1'b1, `EXU_OP_ADD, 5'd15, 5'd0, 5'd0, 32'hBEEF, 1'b1, `EXU_NPC_JAL,
            `EXU_WB_LINK);
    alu_reg(5'd16, 5'd14, 5'd15, `EXU_OP_ADD);
    alu_imm(5'd17, 5'd16, `EXU_OP_XOR, 32'h5A5A_0000);
    alu_reg(5'd18, 5'd17, 5'd14, `EXU_OP_SUB);
    drain("test 5 flush", base);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
  end

  always #(PERIOD_NS / 2) clock = ~clock;

endmodule
